//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module rename_core_tb -f rename_core.f -Mdir obj_dir
	./obj_dir/Vrename_core_tb | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/core_types_pkg.sv
package core_types_pkg;

  // Default datapath width, used as a parameter default
  localparam int DATA_W = 16;

  localparam int GPR_IDX_W = 3;
  localparam int ROB_TAG_W = 3;

  // Position of Z inside an NZCV word
  localparam int NZCV_Z = 2;

  // Architectural register value
  typedef logic [DATA_W-1:0] reg_value_t;

  // Index into the general register file
  typedef logic [GPR_IDX_W-1:0] reg_idx_t;

  // Reorder buffer entry index
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  // Flags ordered N, Z, C, V from the top bit down
  typedef logic [3:0] nzcv_t;

endpackage

//--- logic/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  input  logic                     in_clk,
  input  logic                     in_rst,
  input  logic                     instr_valid,
  input  isa_pkg::instr_word_t     instr_word,
  input  logic                     rob_has_room,
  output logic                     instr_ready,
  output logic                     dec_done,
  output isa_pkg::fu_op_t          dec_op,
  output core_types_pkg::reg_idx_t dec_dst,
  output core_types_pkg::reg_idx_t dec_src1,
  output core_types_pkg::reg_idx_t dec_src2,
  output isa_pkg::imm_t            dec_imm,
  output logic                     dec_set_nzcv,
  output logic                     dec_uses_nzcv,
  output logic                     dec_uses_imm,
  output logic                     dec_writes_dst
);

  logic                     accept;
  isa_pkg::fu_op_t          word_op;
  core_types_pkg::reg_idx_t word_dst;

  // Back-pressure comes straight from the ROB
  assign instr_ready = rob_has_room;
  assign accept      = instr_valid && instr_ready;

  assign word_op  = isa_pkg::fu_op_t'(instr_word[isa_pkg::OP_LSB +: isa_pkg::OP_W]);
  assign word_dst = instr_word[isa_pkg::DST_LSB +: isa_pkg::REG_W];

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      dec_done <= 1'b0;
    end else begin
      dec_done <= accept;
    end
  end

  // Decoded fields load only on a transfer
  always_ff @(posedge in_clk) begin
    if (accept) begin
      dec_op   <= word_op;
      dec_dst  <= word_dst;
      dec_src1 <= instr_word[isa_pkg::SRC1_LSB +: isa_pkg::REG_W];
      dec_src2 <= instr_word[isa_pkg::SRC2_LSB +: isa_pkg::REG_W];
      dec_imm  <= instr_word[isa_pkg::IMM_LSB +: isa_pkg::IMM_W];

      dec_set_nzcv  <= (word_op == isa_pkg::FU_OP_SUBS);
      dec_uses_nzcv <= (word_op == isa_pkg::FU_OP_CSEL_EQ);
      dec_uses_imm  <= (word_op == isa_pkg::FU_OP_ADDI) || (word_op == isa_pkg::FU_OP_MOVI);
      // SUBS into r0 is a compare, only the flags change
      dec_writes_dst <= !((word_op == isa_pkg::FU_OP_SUBS) && (word_dst == '0));
    end
  end

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

  localparam int OP_W  = 3;
  localparam int REG_W = 3;
  localparam int IMM_W = 8;

  localparam int INSTR_W = OP_W + 3 * REG_W + IMM_W;

  // Field positions, opcode at the top and immediate at the bottom
  localparam int IMM_LSB  = 0;
  localparam int SRC2_LSB = IMM_LSB + IMM_W;
  localparam int SRC1_LSB = SRC2_LSB + REG_W;
  localparam int DST_LSB  = SRC1_LSB + REG_W;
  localparam int OP_LSB   = DST_LSB + REG_W;

  typedef logic [INSTR_W-1:0] instr_word_t;

  typedef logic [IMM_W-1:0] imm_t;

  typedef enum logic [OP_W-1:0] {
    FU_OP_ADD     = 3'd0,
    FU_OP_SUB     = 3'd1,
    FU_OP_AND     = 3'd2,
    FU_OP_ORR     = 3'd3,
    FU_OP_ADDI    = 3'd4,
    FU_OP_SUBS    = 3'd5,
    FU_OP_CSEL_EQ = 3'd6,
    FU_OP_MOVI    = 3'd7
  } fu_op_t;

endpackage

//--- logic/reg_rename_file.sv
`timescale 1ns/10ps

module reg_rename_file #(
  parameter int GPR_COUNT = 8
) (
  input  logic                       in_clk,
  input  logic                       in_rst,
  input  logic                       dec_done,
  input  isa_pkg::fu_op_t            dec_op,
  input  core_types_pkg::reg_idx_t   dec_dst,
  input  core_types_pkg::reg_idx_t   dec_src1,
  input  core_types_pkg::reg_idx_t   dec_src2,
  input  isa_pkg::imm_t              dec_imm,
  input  logic                       dec_set_nzcv,
  input  logic                       dec_uses_nzcv,
  input  logic                       dec_uses_imm,
  input  logic                       dec_writes_dst,
  input  core_types_pkg::rob_tag_t   rob_tail_tag,
  input  logic                       commit_valid,
  input  core_types_pkg::rob_tag_t   commit_tag,
  input  core_types_pkg::reg_idx_t   commit_dst,
  input  core_types_pkg::reg_value_t commit_value,
  input  logic                       commit_writes_dst,
  input  logic                       commit_set_nzcv,
  input  core_types_pkg::nzcv_t      commit_nzcv,
  output logic                       disp_valid,
  output logic                       disp_src1_ready,
  output core_types_pkg::reg_value_t disp_src1_value,
  output core_types_pkg::rob_tag_t   disp_src1_tag,
  output logic                       disp_src2_ready,
  output core_types_pkg::reg_value_t disp_src2_value,
  output core_types_pkg::rob_tag_t   disp_src2_tag,
  output logic                       disp_nzcv_ready,
  output core_types_pkg::nzcv_t      disp_nzcv_value,
  output core_types_pkg::rob_tag_t   disp_nzcv_tag,
  output isa_pkg::fu_op_t            disp_op,
  output core_types_pkg::reg_idx_t   disp_dst,
  output logic                       disp_set_nzcv,
  output logic                       disp_writes_dst
);

  // Architectural state with a pending tag per register
  core_types_pkg::reg_value_t reg_value [GPR_COUNT];
  logic                       reg_ready [GPR_COUNT];
  core_types_pkg::rob_tag_t   reg_tag   [GPR_COUNT];
  core_types_pkg::nzcv_t      nzcv_value;
  logic                       nzcv_ready;
  core_types_pkg::rob_tag_t   nzcv_tag;

  // Decoded fields held for the dispatch cycle
  logic                     d_done;
  isa_pkg::fu_op_t          d_op;
  core_types_pkg::reg_idx_t d_dst;
  core_types_pkg::reg_idx_t d_src1;
  core_types_pkg::reg_idx_t d_src2;
  isa_pkg::imm_t            d_imm;
  logic                     d_set_nzcv;
  logic                     d_uses_nzcv;
  logic                     d_uses_imm;
  logic                     d_writes_dst;

  logic commit_reg_hit;
  logic commit_nzcv_hit;

  // Only the latest producer of a register may retire it
  assign commit_reg_hit  = commit_valid && commit_writes_dst &&
                           (commit_tag == reg_tag[commit_dst]);
  assign commit_nzcv_hit = commit_valid && commit_set_nzcv && (commit_tag == nzcv_tag);

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      d_done     <= 1'b0;
      nzcv_value <= '0;
      nzcv_ready <= 1'b1;
      nzcv_tag   <= '0;
      for (int i = 0; i < GPR_COUNT; i++) begin
        reg_value[i] <= '0;
        reg_ready[i] <= 1'b1;
        reg_tag[i]   <= '0;
      end
    end else begin
      d_done <= dec_done;
      if (commit_reg_hit) begin
        reg_value[commit_dst] <= commit_value;
        reg_ready[commit_dst] <= 1'b1;
      end
      if (commit_nzcv_hit) begin
        nzcv_value <= commit_nzcv;
        nzcv_ready <= 1'b1;
      end
      // Rename last, it overrides a same-cycle commit
      if (d_done && d_writes_dst) begin
        reg_ready[d_dst] <= 1'b0;
        reg_tag[d_dst]   <= rob_tail_tag;
      end
      if (d_done && d_set_nzcv) begin
        nzcv_ready <= 1'b0;
        nzcv_tag   <= rob_tail_tag;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (dec_done) begin
      d_op         <= dec_op;
      d_dst        <= dec_dst;
      d_src1       <= dec_src1;
      d_src2       <= dec_src2;
      d_imm        <= dec_imm;
      d_set_nzcv   <= dec_set_nzcv;
      d_uses_nzcv  <= dec_uses_nzcv;
      d_uses_imm   <= dec_uses_imm;
      d_writes_dst <= dec_writes_dst;
    end
  end

  // Reads see pre-rename state, so src == dst gets the older tag
  assign disp_valid      = d_done;
  assign disp_src1_ready = reg_ready[d_src1];
  assign disp_src1_value = reg_value[d_src1];
  assign disp_src1_tag   = reg_tag[d_src1];

  // Zero-extended immediate replaces source 2
  assign disp_src2_ready = d_uses_imm || reg_ready[d_src2];
  assign disp_src2_value = d_uses_imm ? core_types_pkg::reg_value_t'(d_imm) : reg_value[d_src2];
  assign disp_src2_tag   = reg_tag[d_src2];

  // Flags count as ready for ops that ignore them
  assign disp_nzcv_ready = !d_uses_nzcv || nzcv_ready;
  assign disp_nzcv_value = nzcv_value;
  assign disp_nzcv_tag   = nzcv_tag;

  assign disp_op         = d_op;
  assign disp_dst        = d_dst;
  assign disp_set_nzcv   = d_set_nzcv;
  assign disp_writes_dst = d_writes_dst;

endmodule

//--- logic/rename_core.sv
`timescale 1ns/10ps

module rename_core #(
  parameter int GPR_COUNT = 8,
  parameter int ROB_DEPTH = 8
) (
  input  logic                       in_clk,
  input  logic                       in_rst,
  input  logic                       instr_valid,
  input  isa_pkg::instr_word_t       instr_word,
  output logic                       instr_ready,
  output logic                       commit_valid,
  output core_types_pkg::rob_tag_t   commit_tag,
  output core_types_pkg::reg_idx_t   commit_dst,
  output core_types_pkg::reg_value_t commit_value,
  output logic                       commit_writes_dst,
  output logic                       commit_set_nzcv,
  output core_types_pkg::nzcv_t      commit_nzcv
);

  logic                       rob_has_room;
  core_types_pkg::rob_tag_t   rob_tail_tag;

  // Decoder to rename file
  logic                       dec_done;
  isa_pkg::fu_op_t            dec_op;
  core_types_pkg::reg_idx_t   dec_dst;
  core_types_pkg::reg_idx_t   dec_src1;
  core_types_pkg::reg_idx_t   dec_src2;
  isa_pkg::imm_t              dec_imm;
  logic                       dec_set_nzcv;
  logic                       dec_uses_nzcv;
  logic                       dec_uses_imm;
  logic                       dec_writes_dst;

  // Rename file to ROB
  logic                       disp_valid;
  logic                       disp_src1_ready;
  core_types_pkg::reg_value_t disp_src1_value;
  core_types_pkg::rob_tag_t   disp_src1_tag;
  logic                       disp_src2_ready;
  core_types_pkg::reg_value_t disp_src2_value;
  core_types_pkg::rob_tag_t   disp_src2_tag;
  logic                       disp_nzcv_ready;
  core_types_pkg::nzcv_t      disp_nzcv_value;
  core_types_pkg::rob_tag_t   disp_nzcv_tag;
  isa_pkg::fu_op_t            disp_op;
  core_types_pkg::reg_idx_t   disp_dst;
  logic                       disp_set_nzcv;
  logic                       disp_writes_dst;

  // Port names match the wires above
  instr_decoder u_decoder (.*);

  reg_rename_file #(
    .GPR_COUNT(GPR_COUNT)
  ) u_rename (.*);

  reorder_buffer #(
    .ROB_DEPTH(ROB_DEPTH)
  ) u_rob (.*);

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                       in_clk,
  input  logic                       in_rst,
  input  logic                       disp_valid,
  input  logic                       disp_src1_ready,
  input  core_types_pkg::reg_value_t disp_src1_value,
  input  core_types_pkg::rob_tag_t   disp_src1_tag,
  input  logic                       disp_src2_ready,
  input  core_types_pkg::reg_value_t disp_src2_value,
  input  core_types_pkg::rob_tag_t   disp_src2_tag,
  input  logic                       disp_nzcv_ready,
  input  core_types_pkg::nzcv_t      disp_nzcv_value,
  input  core_types_pkg::rob_tag_t   disp_nzcv_tag,
  input  isa_pkg::fu_op_t            disp_op,
  input  core_types_pkg::reg_idx_t   disp_dst,
  input  logic                       disp_set_nzcv,
  input  logic                       disp_writes_dst,
  output core_types_pkg::rob_tag_t   rob_tail_tag,
  output logic                       rob_has_room,
  output logic                       commit_valid,
  output core_types_pkg::rob_tag_t   commit_tag,
  output core_types_pkg::reg_idx_t   commit_dst,
  output core_types_pkg::reg_value_t commit_value,
  output logic                       commit_writes_dst,
  output logic                       commit_set_nzcv,
  output core_types_pkg::nzcv_t      commit_nzcv
);

  localparam int DW    = core_types_pkg::DATA_W;
  localparam int CNT_W = $clog2(ROB_DEPTH + 1);

  typedef enum logic {EMPTY, WAITING} entry_state_t;

  entry_state_t               state          [ROB_DEPTH];
  isa_pkg::fu_op_t            e_op           [ROB_DEPTH];
  core_types_pkg::reg_idx_t   e_dst          [ROB_DEPTH];
  logic                       e_writes_dst   [ROB_DEPTH];
  logic                       e_set_nzcv     [ROB_DEPTH];
  logic                       e_src1_ready   [ROB_DEPTH];
  core_types_pkg::reg_value_t e_src1_value   [ROB_DEPTH];
  core_types_pkg::rob_tag_t   e_src1_tag     [ROB_DEPTH];
  logic                       e_src2_ready   [ROB_DEPTH];
  core_types_pkg::reg_value_t e_src2_value   [ROB_DEPTH];
  core_types_pkg::rob_tag_t   e_src2_tag     [ROB_DEPTH];
  logic                       e_nzcv_ready   [ROB_DEPTH];
  core_types_pkg::nzcv_t      e_nzcv_value   [ROB_DEPTH];
  core_types_pkg::rob_tag_t   e_nzcv_tag     [ROB_DEPTH];

  core_types_pkg::rob_tag_t   head;
  core_types_pkg::rob_tag_t   tail;
  logic [CNT_W-1:0]           count;
  logic [CNT_W-1:0]           count_next;

  core_types_pkg::reg_value_t op_a;
  core_types_pkg::reg_value_t op_b;
  core_types_pkg::nzcv_t      op_f;
  logic [DW:0]                sub_full;
  logic                       wake_value;
  logic                       wake_nzcv;

  function automatic core_types_pkg::rob_tag_t next_ptr(core_types_pkg::rob_tag_t p);
    return (p == core_types_pkg::rob_tag_t'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign rob_tail_tag = tail;

  // Head entry executes as soon as its operands are in
  assign op_a = e_src1_value[head];
  assign op_b = e_src2_value[head];
  assign op_f = e_nzcv_value[head];

  // a + ~b + 1, carry out means no borrow
  assign sub_full = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;

  assign commit_valid = (state[head] == WAITING) &&
                        (e_src1_ready[head] || (e_op[head] == isa_pkg::FU_OP_MOVI)) &&
                        e_src2_ready[head] && e_nzcv_ready[head];
  assign commit_tag        = head;
  assign commit_dst        = e_dst[head];
  assign commit_writes_dst = e_writes_dst[head];
  assign commit_set_nzcv   = e_set_nzcv[head];
  assign commit_nzcv       = {sub_full[DW-1],
                              (sub_full[DW-1:0] == '0),
                              sub_full[DW],
                              (op_a[DW-1] != op_b[DW-1]) && (sub_full[DW-1] != op_a[DW-1])};

  always_comb begin
    commit_value = op_a + op_b;
    case (e_op[head])
      isa_pkg::FU_OP_SUB:     commit_value = op_a - op_b;
      isa_pkg::FU_OP_AND:     commit_value = op_a & op_b;
      isa_pkg::FU_OP_ORR:     commit_value = op_a | op_b;
      isa_pkg::FU_OP_SUBS:    commit_value = sub_full[DW-1:0];
      isa_pkg::FU_OP_CSEL_EQ: commit_value = op_f[core_types_pkg::NZCV_Z] ? op_a : op_b;
      isa_pkg::FU_OP_MOVI:    commit_value = op_b;
      default:                commit_value = op_a + op_b;
    endcase
  end

  // What the commit broadcast carries for waiting operands
  assign wake_value = commit_valid && commit_writes_dst;
  assign wake_nzcv  = commit_valid && commit_set_nzcv;

  always_comb begin
    count_next = count + CNT_W'(disp_valid) - CNT_W'(commit_valid);
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      rob_has_room <= 1'b0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        state[i] <= EMPTY;
      end
    end else begin
      count <= count_next;
      // Leave space for the two words still in decode and rename
      rob_has_room <= (count_next <= CNT_W'(ROB_DEPTH - 3));
      if (commit_valid) begin
        state[head] <= EMPTY;
        head        <= next_ptr(head);
      end
      if (disp_valid) begin
        state[tail] <= WAITING;
        tail        <= next_ptr(tail);
      end
    end
  end

  always_ff @(posedge in_clk) begin
    // Wakeup of waiting operands
    for (int i = 0; i < ROB_DEPTH; i++) begin
      if (state[i] == WAITING) begin
        if (wake_value && !e_src1_ready[i] && (e_src1_tag[i] == commit_tag)) begin
          e_src1_ready[i] <= 1'b1;
          e_src1_value[i] <= commit_value;
        end
        if (wake_value && !e_src2_ready[i] && (e_src2_tag[i] == commit_tag)) begin
          e_src2_ready[i] <= 1'b1;
          e_src2_value[i] <= commit_value;
        end
        if (wake_nzcv && !e_nzcv_ready[i] && (e_nzcv_tag[i] == commit_tag)) begin
          e_nzcv_ready[i] <= 1'b1;
          e_nzcv_value[i] <= commit_nzcv;
        end
      end
    end
    if (disp_valid) begin
      e_op[tail]         <= disp_op;
      e_dst[tail]        <= disp_dst;
      e_writes_dst[tail] <= disp_writes_dst;
      e_set_nzcv[tail]   <= disp_set_nzcv;
      e_src1_tag[tail]   <= disp_src1_tag;
      e_src2_tag[tail]   <= disp_src2_tag;
      e_nzcv_tag[tail]   <= disp_nzcv_tag;
      // Producer may be committing in the dispatch cycle itself
      e_src1_ready[tail] <= disp_src1_ready || (wake_value && (disp_src1_tag == commit_tag));
      e_src1_value[tail] <= disp_src1_ready ? disp_src1_value : commit_value;
      e_src2_ready[tail] <= disp_src2_ready || (wake_value && (disp_src2_tag == commit_tag));
      e_src2_value[tail] <= disp_src2_ready ? disp_src2_value : commit_value;
      e_nzcv_ready[tail] <= disp_nzcv_ready || (wake_nzcv && (disp_nzcv_tag == commit_tag));
      e_nzcv_value[tail] <= disp_nzcv_ready ? disp_nzcv_value : commit_nzcv;
    end
  end

endmodule

//--- rename_core.f
logic/core_types_pkg.sv
logic/isa_pkg.sv
logic/instr_decoder.sv
logic/reg_rename_file.sv
logic/reorder_buffer.sv
logic/rename_core.sv
sim/rename_core_asserts.sv
sim/rename_core_tb.sv

//--- sim/rename_core_asserts.sv
`timescale 1ns/10ps

module rename_core_asserts #(
  parameter int ROB_DEPTH = 8
) (
  input logic                     in_clk,
  input logic                     in_rst,
  input logic                     instr_valid,
  input logic                     instr_ready,
  input logic                     disp_valid,
  input logic                     commit_valid,
  input core_types_pkg::rob_tag_t commit_tag
);

  // Tag the next commit has to carry
  core_types_pkg::rob_tag_t next_tag;

  // Assertion failures so far
  int fail_count = 0;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      next_tag <= '0;
    end else if (commit_valid) begin
      next_tag <= (next_tag == core_types_pkg::rob_tag_t'(ROB_DEPTH - 1)) ? '0 : next_tag + 1'b1;
    end
  end

  commit_known: assert property (@(posedge in_clk) disable iff (in_rst)
    !$isunknown(commit_valid))
    else begin
      fail_count++;
      $error("commit_valid is unknown");
    end

  commit_in_order: assert property (@(posedge in_clk) disable iff (in_rst)
    commit_valid |-> (commit_tag == next_tag))
    else begin
      fail_count++;
      $error("commit tag %0d out of order, expected %0d", commit_tag, next_tag);
    end

  // Decode and rename each take one cycle
  disp_after_accept: assert property (@(posedge in_clk) disable iff (in_rst)
    disp_valid |-> $past(instr_valid && instr_ready, 2))
    else begin
      fail_count++;
      $error("disp_valid without an instruction accepted two cycles before");
    end

endmodule

//--- sim/rename_core_tb.sv
`timescale 1ns/10ps

module rename_core_tb;

  localparam int GPR_COUNT  = 8;
  localparam int ROB_DEPTH  = 8;
  localparam int NUM_INSTR  = 300;
  localparam int WAIT_LIMIT = 200;

  logic                       in_clk;
  logic                       in_rst;
  logic                       instr_valid;
  isa_pkg::instr_word_t       instr_word;
  logic                       instr_ready;
  logic                       commit_valid;
  core_types_pkg::rob_tag_t   commit_tag;
  core_types_pkg::reg_idx_t   commit_dst;
  core_types_pkg::reg_value_t commit_value;
  logic                       commit_writes_dst;
  logic                       commit_set_nzcv;
  core_types_pkg::nzcv_t      commit_nzcv;

  // Expected commit packed as dst, write, set flags, nzcv and value
  logic [24:0]                exp_q [$];
  core_types_pkg::reg_value_t model_reg [GPR_COUNT];
  core_types_pkg::nzcv_t      model_nzcv;
  logic [31:0]                rng_state;
  int                         outstanding;
  int                         accepted_count;
  int                         commit_count;
  int                         value_errors;
  int                         other_errors;
  logic                       timed_out;

  rename_core #(
    .GPR_COUNT(GPR_COUNT),
    .ROB_DEPTH(ROB_DEPTH)
  ) UUT (.*);

  bind rename_core rename_core_asserts #(.ROB_DEPTH(ROB_DEPTH)) u_asserts (.*);

  initial begin
    in_clk = 1'b0;
    forever #2 in_clk = ~in_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Architectural model, executes one word in program order
  function automatic logic [24:0] model_step(input isa_pkg::instr_word_t w);
    logic [2:0]                 op;
    core_types_pkg::reg_idx_t   dst;
    core_types_pkg::reg_value_t a;
    core_types_pkg::reg_value_t b;
    core_types_pkg::reg_value_t r;
    core_types_pkg::nzcv_t      f;
    logic                       sets;
    logic                       writes;
    op  = w[19:17];
    dst = w[16:14];
    a   = model_reg[w[13:11]];
    b   = model_reg[w[10:8]];
    r   = a - b;
    // C means no borrow and V is signed overflow of a - b
    f   = {r[15], (r == '0), (a >= b), (a[15] != b[15]) && (r[15] != a[15])};
    case (op)
      isa_pkg::FU_OP_ADD:     r = a + b;
      isa_pkg::FU_OP_AND:     r = a & b;
      isa_pkg::FU_OP_ORR:     r = a | b;
      isa_pkg::FU_OP_ADDI:    r = a + {8'h00, w[7:0]};
      isa_pkg::FU_OP_CSEL_EQ: r = model_nzcv[2] ? a : b;
      isa_pkg::FU_OP_MOVI:    r = {8'h00, w[7:0]};
      default:                r = a - b;
    endcase
    sets   = (op == isa_pkg::FU_OP_SUBS);
    // SUBS into r0 acts as a compare
    writes = !(sets && (dst == '0));
    if (writes) begin
      model_reg[dst] = r;
    end
    if (sets) begin
      model_nzcv = f;
    end
    return {dst, writes, sets, f, r};
  endfunction

  function automatic isa_pkg::instr_word_t make_word(input logic [2:0] prev_op);
    logic [31:0] r;
    logic [2:0]  op;
    logic [2:0]  dst;
    logic [2:0]  s1;
    logic [2:0]  s2;
    r  = draw();
    op = r[2:0];
    if ((prev_op == isa_pkg::FU_OP_SUBS) && r[3]) begin
      op = isa_pkg::FU_OP_CSEL_EQ;
    end
    // Mostly r0..r3 so results feed each other
    dst = (r[4] && r[5]) ? r[8:6] : {1'b0, r[7:6]};
    s1  = (r[9] && r[10]) ? r[13:11] : {1'b0, r[12:11]};
    s2  = (r[14] && r[15]) ? r[18:16] : {1'b0, r[17:16]};
    if (r[19] && r[20]) begin
      s1 = dst;
    end
    return {op, dst, s1, s2, r[31:24]};
  endfunction

  task automatic send_word(input isa_pkg::instr_word_t w);
    int waited;
    waited      = 0;
    instr_valid = 1'b1;
    instr_word  = w;
    @(negedge in_clk);
    while (!instr_ready && (waited < WAIT_LIMIT)) begin
      @(negedge in_clk);
      waited++;
    end
    if (!instr_ready) begin
      $display("Timed out waiting for instr_ready");
      other_errors++;
      timed_out = 1'b1;
    end
    @(posedge in_clk);
    #1;
    instr_valid = 1'b0;
  endtask

  always @(negedge in_clk) begin : monitor
    logic [24:0] e;
    if (!in_rst) begin
      if (commit_valid === 1'b1) begin
        commit_count++;
        assert (exp_q.size() != 0) else begin
          $display("Commit seen with no instruction outstanding");
          other_errors++;
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          assert (commit_dst === e[24:22]) else begin
            $display("FAILED commit_dst: got %h expected %h", commit_dst, e[24:22]);
            value_errors++;
          end
          assert (commit_writes_dst === e[21]) else begin
            $display("FAILED commit_writes_dst: got %h expected %h", commit_writes_dst, e[21]);
            value_errors++;
          end
          assert (commit_value === e[15:0]) else begin
            $display("FAILED commit_value: got %h expected %h", commit_value, e[15:0]);
            value_errors++;
          end
          assert (commit_set_nzcv === e[20]) else begin
            $display("FAILED commit_set_nzcv: got %h expected %h", commit_set_nzcv, e[20]);
            value_errors++;
          end
          if (e[20]) begin
            assert (commit_nzcv === e[19:16]) else begin
              $display("FAILED commit_nzcv: got %h expected %h", commit_nzcv, e[19:16]);
              value_errors++;
            end
          end
        end
      end
      if (instr_valid && instr_ready) begin
        accepted_count++;
        exp_q.push_back(model_step(instr_word));
      end
      outstanding = outstanding + int'(instr_valid && instr_ready) - int'(commit_valid === 1'b1);
      assert (outstanding <= ROB_DEPTH) else begin
        $display("More instructions outstanding than the ROB can hold");
        other_errors++;
      end
    end
  end

  initial begin
    int                   sent;
    int                   gap;
    int                   duty;
    int                   waited;
    logic [2:0]           prev_op;
    isa_pkg::instr_word_t w;
    in_rst         = 1'b1;
    instr_valid    = 1'b0;
    instr_word     = '0;
    rng_state      = 32'd56084;
    outstanding    = 0;
    accepted_count = 0;
    commit_count   = 0;
    value_errors   = 0;
    other_errors   = 0;
    timed_out      = 1'b0;
    model_nzcv     = '0;
    for (int i = 0; i < GPR_COUNT; i++) begin
      model_reg[i] = '0;
    end
    repeat (8) @(posedge in_clk);
    #1;
    in_rst = 1'b0;

    // Idle pipeline must not commit anything
    repeat (10) begin
      @(negedge in_clk);
      assert (commit_valid === 1'b0) else begin
        $display("commit_valid went high with no instruction sent");
        other_errors++;
      end
    end
    @(posedge in_clk);
    #1;
    // r1 = r2 + r3 straight after reset
    send_word({isa_pkg::FU_OP_ADD, 3'd1, 3'd2, 3'd3, 8'h00});
    prev_op = isa_pkg::FU_OP_ADD;
    duty    = 4;
    sent    = 1;

    while ((sent < NUM_INSTR) && !timed_out) begin
      if (sent % 50 == 0) begin
        duty = int'(draw() % 5);
      end
      w       = make_word(prev_op);
      prev_op = w[19:17];
      send_word(w);
      sent++;
      if (int'(draw() % 4) >= duty) begin
        gap = int'(draw() % 3) + 1;
        repeat (gap) @(posedge in_clk);
        #1;
      end
    end

    waited = 0;
    while ((exp_q.size() != 0) && (waited < WAIT_LIMIT)) begin
      @(negedge in_clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out with %0d commits still missing", exp_q.size());
      other_errors++;
    end
    // Catch any stray commit after the drain
    repeat (5) @(negedge in_clk);
    assert ((commit_count == accepted_count) && (accepted_count == sent)) else begin
      $display("Sent %0d, accepted %0d and committed %0d instructions",
               sent, accepted_count, commit_count);
      other_errors++;
    end

    $display("Errors: %0d wrong values, %0d other, %0d bound assertions",
             value_errors, other_errors, UUT.u_asserts.fail_count);
    if ((value_errors == 0) && (other_errors == 0) && (UUT.u_asserts.fail_count == 0)) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
